//--- Makefile
# Verilator build and run for the sideband repeater

VERILATOR ?= verilator
TOP       ?= tb_sb_repeater
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
sb_pkg.sv
sb_ingress_arb.sv
sb_repeater_stage.sv
sb_target_decode.sv
sb_repeater_top.sv
tb_sb_repeater.sv

//--- sb_ingress_arb.sv
`timescale 1ns/1ns
`default_nettype none

module sb_ingress_arb (
  input  logic                      ccu_if,
  input  logic                      rst,
  input  logic                      pc_valid,
  output logic                      pc_ready,
  input  logic [sb_pkg::FLIT_W-1:0] pc_payload,
  input  logic                      pc_eom,
  input  logic                      np_valid,
  output logic                      np_ready,
  input  logic [sb_pkg::FLIT_W-1:0] np_payload,
  input  logic                      np_eom,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [sb_pkg::FLIT_W-1:0] out_payload,
  output logic                      out_eom,
  output logic                      out_np
);

  logic                      msg_ip;
  logic                      lock_np;
  logic                      sel_np;
  logic                      in_xfer;
  logic [sb_pkg::FLIT_W-1:0] sel_payload;
  logic                      sel_eom;

  // pc wins at a boundary, otherwise stay on the locked channel
  assign sel_np = msg_ip ? lock_np : !pc_valid;

  // output register is empty or draining whenever downstream is ready
  assign pc_ready = out_ready && !sel_np;
  assign np_ready = out_ready && sel_np;

  assign in_xfer     = sel_np ? (np_valid && np_ready) : (pc_valid && pc_ready);
  assign sel_payload = sel_np ? np_payload : pc_payload;
  assign sel_eom     = sel_np ? np_eom : pc_eom;

  //****************************************
  // grant and message tracking
  //****************************************
  always_ff @(posedge ccu_if)
  begin
    if (rst)
    begin
      msg_ip    <= 1'b0;
      lock_np   <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      if (in_xfer)
      begin
        msg_ip  <= !sel_eom;
        lock_np <= sel_np;
      end
      if (out_ready)
        out_valid <= in_xfer;
    end
  end

  // output flit with its channel tag
  always_ff @(posedge ccu_if)
  begin
    if (in_xfer)
    begin
      out_payload <= sel_payload;
      out_eom     <= sel_eom;
      out_np      <= sel_np;
    end
  end

  // no channel switch in the middle of a message
  assert property (@(posedge ccu_if) disable iff (rst)
    (out_valid && out_ready && !out_eom) |=> (out_np == $past(out_np)));

endmodule

`default_nettype wire

//--- sb_pkg.sv
`default_nettype none

package sb_pkg;

  //****************************************
  // flit and pipe geometry
  //****************************************
  localparam int FLIT_W             = 32;
  localparam int NUM_REPEATER_FLOPS = 3;

  // arbiter flop, repeater flops, decode flop
  localparam int PIPE_LATENCY = NUM_REPEATER_FLOPS + 2;

  //****************************************
  // header layout
  //****************************************
  localparam int PORT_ID_W = 8;
  localparam int OPCODE_W  = 8;
  localparam int TAG_W     = 3;

  localparam logic [PORT_ID_W-1:0] LOCAL_PORT_ID = 8'h2A;

  // first flit of every message, msb first
  typedef struct packed {
    logic [PORT_ID_W-1:0] dest;
    logic [PORT_ID_W-1:0] source;
    logic [OPCODE_W-1:0]  opcode;
    logic                 eh;
    logic [TAG_W-1:0]     tag;
    logic [3:0]           rsvd;
  } sb_hdr_t;

  // header view on the first flit, raw word on the rest
  typedef union packed {
    sb_hdr_t           hdr;
    logic [FLIT_W-1:0] data;
  } sb_flit_u;

endpackage

`default_nettype wire

//--- sb_repeater_stage.sv
`timescale 1ns/1ns
`default_nettype none

module sb_repeater_stage (
  input  logic                      ccu_if,
  input  logic                      rst,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [sb_pkg::FLIT_W-1:0] in_payload,
  input  logic                      in_eom,
  input  logic                      in_np,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [sb_pkg::FLIT_W-1:0] out_payload,
  output logic                      out_eom,
  output logic                      out_np
);

  logic                      skid_valid;
  logic                      skid_valid_d;
  logic [sb_pkg::FLIT_W-1:0] skid_payload;
  logic                      skid_eom;
  logic                      skid_np;
  logic                      in_xfer;
  logic                      main_free;
  logic                      load_skid;
  logic                      load_in;
  logic                      fill_skid;

  assign in_xfer   = in_valid && in_ready;
  assign main_free = !out_valid || out_ready;

  // skid drains first, so order is kept
  assign load_skid = main_free && skid_valid;
  assign load_in   = main_free && !skid_valid && in_xfer;
  assign fill_skid = !main_free && in_xfer;

  assign skid_valid_d = load_skid ? 1'b0 : (fill_skid ? 1'b1 : skid_valid);

  always_ff @(posedge ccu_if)
  begin
    if (rst)
    begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end
    else
    begin
      if (main_free)
        out_valid <= skid_valid || in_xfer;
      skid_valid <= skid_valid_d;
      // registered ready, breaks the ready chain between stages
      in_ready   <= !skid_valid_d;
    end
  end

  always_ff @(posedge ccu_if)
  begin
    if (load_skid)
    begin
      out_payload <= skid_payload;
      out_eom     <= skid_eom;
      out_np      <= skid_np;
    end
    else if (load_in)
    begin
      out_payload <= in_payload;
      out_eom     <= in_eom;
      out_np      <= in_np;
    end
    if (fill_skid)
    begin
      skid_payload <= in_payload;
      skid_eom     <= in_eom;
      skid_np      <= in_np;
    end
  end

  // stalled output holds
  assert property (@(posedge ccu_if) disable iff (rst)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_payload) && $stable(out_eom) && $stable(out_np)));

endmodule

`default_nettype wire

//--- sb_repeater_top.sv
`timescale 1ns/1ns
`default_nettype none

// arbiter, repeater flops and decode in one chain
// idle latency input to output is sb_pkg::PIPE_LATENCY cycles
module sb_repeater_top (
  input  logic                      ccu_if,
  input  logic                      rst,
  input  logic                      pc_valid,
  output logic                      pc_ready,
  input  logic [sb_pkg::FLIT_W-1:0] pc_payload,
  input  logic                      pc_eom,
  input  logic                      np_valid,
  output logic                      np_ready,
  input  logic [sb_pkg::FLIT_W-1:0] np_payload,
  input  logic                      np_eom,
  output logic                      tmsg_pc_valid,
  input  logic                      tmsg_pc_ready,
  output logic [sb_pkg::FLIT_W-1:0] tmsg_pc_payload,
  output logic                      tmsg_pc_eom,
  output logic                      tmsg_np_valid,
  input  logic                      tmsg_np_ready,
  output logic [sb_pkg::FLIT_W-1:0] tmsg_np_payload,
  output logic                      tmsg_np_eom
);

  localparam int N = sb_pkg::NUM_REPEATER_FLOPS;

  // link 0 from the arbiter, link N into the decode
  logic                      link_valid   [0:N];
  logic                      link_ready   [0:N];
  logic [sb_pkg::FLIT_W-1:0] link_payload [0:N];
  logic                      link_eom     [0:N];
  logic                      link_np      [0:N];

  sb_ingress_arb u_arb (
    .ccu_if      (ccu_if),
    .rst         (rst),
    .pc_valid    (pc_valid),
    .pc_ready    (pc_ready),
    .pc_payload  (pc_payload),
    .pc_eom      (pc_eom),
    .np_valid    (np_valid),
    .np_ready    (np_ready),
    .np_payload  (np_payload),
    .np_eom      (np_eom),
    .out_valid   (link_valid[0]),
    .out_ready   (link_ready[0]),
    .out_payload (link_payload[0]),
    .out_eom     (link_eom[0]),
    .out_np      (link_np[0])
  );

  //****************************************
  // repeater chain
  //****************************************
  for (genvar i = 0; i < N; i++)
  begin : g_rep
    sb_repeater_stage u_stage (
      .ccu_if      (ccu_if),
      .rst         (rst),
      .in_valid    (link_valid[i]),
      .in_ready    (link_ready[i]),
      .in_payload  (link_payload[i]),
      .in_eom      (link_eom[i]),
      .in_np       (link_np[i]),
      .out_valid   (link_valid[i+1]),
      .out_ready   (link_ready[i+1]),
      .out_payload (link_payload[i+1]),
      .out_eom     (link_eom[i+1]),
      .out_np      (link_np[i+1])
    );
  end

  sb_target_decode u_decode (
    .ccu_if          (ccu_if),
    .rst             (rst),
    .in_valid        (link_valid[N]),
    .in_ready        (link_ready[N]),
    .in_payload      (link_payload[N]),
    .in_eom          (link_eom[N]),
    .in_np           (link_np[N]),
    .tmsg_pc_valid   (tmsg_pc_valid),
    .tmsg_pc_ready   (tmsg_pc_ready),
    .tmsg_pc_payload (tmsg_pc_payload),
    .tmsg_pc_eom     (tmsg_pc_eom),
    .tmsg_np_valid   (tmsg_np_valid),
    .tmsg_np_ready   (tmsg_np_ready),
    .tmsg_np_payload (tmsg_np_payload),
    .tmsg_np_eom     (tmsg_np_eom)
  );

endmodule

`default_nettype wire

//--- sb_target_decode.sv
`timescale 1ns/1ns
`default_nettype none

module sb_target_decode (
  input  logic                      ccu_if,
  input  logic                      rst,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [sb_pkg::FLIT_W-1:0] in_payload,
  input  logic                      in_eom,
  input  logic                      in_np,
  output logic                      tmsg_pc_valid,
  input  logic                      tmsg_pc_ready,
  output logic [sb_pkg::FLIT_W-1:0] tmsg_pc_payload,
  output logic                      tmsg_pc_eom,
  output logic                      tmsg_np_valid,
  input  logic                      tmsg_np_ready,
  output logic [sb_pkg::FLIT_W-1:0] tmsg_np_payload,
  output logic                      tmsg_np_eom
);

  sb_pkg::sb_flit_u in_flit;
  logic             sof;
  logic             deliver_q;
  logic             deliver_now;
  logic             out_free;
  logic             in_xfer;
  logic             take_pc;
  logic             take_np;

  assign in_flit = in_payload;

  // decision comes from the header, then sticks for the message
  assign deliver_now = sof ? (in_flit.hdr.dest == sb_pkg::LOCAL_PORT_ID) : deliver_q;

  // both output registers free after this edge
  assign out_free = !(tmsg_pc_valid && !tmsg_pc_ready) &&
                    !(tmsg_np_valid && !tmsg_np_ready);

  // dropped flits are always taken
  assign in_ready = deliver_now ? out_free : 1'b1;
  assign in_xfer  = in_valid && in_ready;
  assign take_pc  = in_xfer && deliver_now && !in_np;
  assign take_np  = in_xfer && deliver_now && in_np;

  //****************************************
  // message framing and output valids
  //****************************************
  always_ff @(posedge ccu_if)
  begin
    if (rst)
    begin
      sof           <= 1'b1;
      deliver_q     <= 1'b0;
      tmsg_pc_valid <= 1'b0;
      tmsg_np_valid <= 1'b0;
    end
    else
    begin
      if (in_xfer)
      begin
        sof       <= in_eom;
        deliver_q <= deliver_now;
      end
      if (out_free)
      begin
        tmsg_pc_valid <= take_pc;
        tmsg_np_valid <= take_np;
      end
    end
  end

  always_ff @(posedge ccu_if)
  begin
    if (take_pc)
    begin
      tmsg_pc_payload <= in_flit.data;
      tmsg_pc_eom     <= in_eom;
    end
    if (take_np)
    begin
      tmsg_np_payload <= in_flit.data;
      tmsg_np_eom     <= in_eom;
    end
  end

  // one output at a time
  assert property (@(posedge ccu_if) disable iff (rst)
    !(tmsg_pc_valid && tmsg_np_valid));

endmodule

`default_nettype wire

//--- tb_sb_repeater.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sb_repeater;

  logic                      ccu_if;
  logic                      rst;
  logic                      pc_valid;
  logic                      pc_ready;
  logic [sb_pkg::FLIT_W-1:0] pc_payload;
  logic                      pc_eom;
  logic                      np_valid;
  logic                      np_ready;
  logic [sb_pkg::FLIT_W-1:0] np_payload;
  logic                      np_eom;
  logic                      tmsg_pc_valid;
  logic                      tmsg_pc_ready;
  logic [sb_pkg::FLIT_W-1:0] tmsg_pc_payload;
  logic                      tmsg_pc_eom;
  logic                      tmsg_np_valid;
  logic                      tmsg_np_ready;
  logic [sb_pkg::FLIT_W-1:0] tmsg_np_payload;
  logic                      tmsg_np_eom;

  // flit words are {eom, payload}
  logic [32:0] pc_in[$];
  logic [32:0] np_in[$];
  logic [32:0] sent_pc[$];
  logic [32:0] sent_np[$];
  logic [32:0] exp_pc[$];
  logic [32:0] exp_np[$];

  int cycle = 0;
  int total_flits = 0;
  int cmp_errors = 0;
  int seq_errors = 0;
  int checks = 0;
  int lat_in = 0;
  int lat_out = 0;
  int msg_id = 0;
  int base = 0;
  bit pc_fire = 1'b0;
  bit np_fire = 1'b0;
  bit backpressure = 1'b0;
  bit gaps = 1'b0;

  sb_repeater_top dut0 (.*);

  initial
  begin
    ccu_if = 1'b0;
    forever #4 ccu_if = ~ccu_if;
  end

  function automatic bit chance(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  //****************************************
  // reference model
  //****************************************
  // a message is kept whole when its header dest is the local port
  function automatic void build_expected(input bit np);
    sb_pkg::sb_flit_u flit;
    logic [32:0]      w;
    bit               at_hdr;
    bit               keep;
    int               n;
    at_hdr = 1'b1;
    keep   = 1'b0;
    n      = np ? sent_np.size() : sent_pc.size();
    for (int i = 0; i < n; i++)
    begin
      w    = np ? sent_np[i] : sent_pc[i];
      flit = w[31:0];
      if (at_hdr)
        keep = flit.hdr.dest == sb_pkg::LOCAL_PORT_ID;
      if (keep && np)
        exp_np.push_back(w);
      if (keep && !np)
        exp_pc.push_back(w);
      at_hdr = w[32];
    end
  endfunction

  task automatic queue_msg(input bit np, input bit to_local, input int len);
    sb_pkg::sb_flit_u hdr;
    logic [31:0]      r;
    logic [32:0]      w;
    r            = $urandom;
    hdr.hdr.dest = to_local ? sb_pkg::LOCAL_PORT_ID : r[7:0];
    if (!to_local && hdr.hdr.dest == sb_pkg::LOCAL_PORT_ID)
      hdr.hdr.dest = ~sb_pkg::LOCAL_PORT_ID;
    // source carries channel and message number for debug
    hdr.hdr.source = {np, msg_id[6:0]};
    hdr.hdr.opcode = r[15:8];
    hdr.hdr.eh     = 1'b0;
    hdr.hdr.tag    = r[18:16];
    hdr.hdr.rsvd   = 4'h0;
    for (int i = 0; i < len; i++)
    begin
      w = {i == len - 1, (i == 0) ? hdr.data : $urandom};
      if (np)
      begin
        sent_np.push_back(w);
        np_in.push_back(w);
      end
      else
      begin
        sent_pc.push_back(w);
        pc_in.push_back(w);
      end
    end
    msg_id++;
    total_flits += len;
  endtask

  task automatic commit_queued();
    build_expected(1'b0);
    build_expected(1'b1);
    sent_pc.delete();
    sent_np.delete();
  endtask

  // inputs empty and every expected flit seen, then a window for strays
  task automatic drain();
    while (pc_in.size() > 0 || np_in.size() > 0 || pc_valid || np_valid ||
           exp_pc.size() > 0 || exp_np.size() > 0)
      @(negedge ccu_if);
    repeat (20) @(negedge ccu_if);
  endtask

  task automatic report(input string name);
    $display("test %s finished with %0d errors", name, cmp_errors + seq_errors - base);
  endtask

  //****************************************
  // sources, sinks and monitors
  //****************************************
  initial
  begin
    pc_valid   = 1'b0;
    pc_payload = '0;
    pc_eom     = 1'b0;
    forever
    begin
      @(negedge ccu_if);
      if (pc_fire || !pc_valid)
      begin
        // idle cycles let the other channel win a boundary
        pc_valid = pc_in.size() > 0 && !(gaps && chance(40));
        if (pc_valid)
          {pc_eom, pc_payload} = pc_in.pop_front();
      end
    end
  end

  initial
  begin
    np_valid   = 1'b0;
    np_payload = '0;
    np_eom     = 1'b0;
    forever
    begin
      @(negedge ccu_if);
      if (np_fire || !np_valid)
      begin
        np_valid = np_in.size() > 0 && !(gaps && chance(40));
        if (np_valid)
          {np_eom, np_payload} = np_in.pop_front();
      end
    end
  end

  initial
  begin
    tmsg_pc_ready = 1'b1;
    tmsg_np_ready = 1'b1;
    forever
    begin
      @(negedge ccu_if);
      tmsg_pc_ready = !backpressure || chance(55);
      tmsg_np_ready = !backpressure || chance(55);
    end
  end

  always @(posedge ccu_if)
  begin
    cycle   <= cycle + 1;
    pc_fire <= pc_valid && pc_ready;
    np_fire <= np_valid && np_ready;
    if (pc_valid && pc_ready)
      lat_in <= cycle;
  end

  task automatic check_flit(input bit np, input logic [32:0] got);
    logic [32:0] want;
    int          left;
    left   = np ? exp_np.size() : exp_pc.size();
    checks = checks + 1;
    assert (left > 0)
    else
    begin
      $display("%0t: %s output gave flit %h while nothing was expected",
               $time, np ? "np" : "pc", got);
      cmp_errors++;
    end
    if (left > 0)
    begin
      if (np)
        want = exp_np.pop_front();
      else
        want = exp_pc.pop_front();
      assert (got === want)
      else
      begin
        $display("Mismatch at %0t: %s output got %h, expected %h",
                 $time, np ? "np" : "pc", got, want);
        cmp_errors++;
      end
    end
  endtask

  always @(posedge ccu_if)
  begin
    if (!rst && tmsg_pc_valid && tmsg_pc_ready)
    begin
      check_flit(1'b0, {tmsg_pc_eom, tmsg_pc_payload});
      lat_out <= cycle;
    end
    if (!rst && tmsg_np_valid && tmsg_np_ready)
      check_flit(1'b1, {tmsg_np_eom, tmsg_np_payload});
  end

  // limit grows with every queued flit
  initial
  begin
    wait (cycle >= 200 + 4 * total_flits);
    $display("timeout after %0d cycles, expected flits never all arrived", cycle);
    $display("TEST FAILED");
    $finish;
  end

  //****************************************
  // test sequence
  //****************************************
  initial
  begin
    void'($urandom(81461));
    rst = 1'b1;
    repeat (10) @(posedge ccu_if);
    @(negedge ccu_if);
    rst = 1'b0;

    base = cmp_errors + seq_errors;
    repeat (6) queue_msg(1'b0, 1'b1, 1 + $urandom % 4);
    commit_queued();
    drain();
    report("pc delivery");

    base = cmp_errors + seq_errors;
    repeat (6) queue_msg(1'b1, 1'b1, 1 + $urandom % 4);
    commit_queued();
    drain();
    report("np delivery");

    base = cmp_errors + seq_errors;
    repeat (12) queue_msg(chance(50), chance(50), 1 + $urandom % 4);
    commit_queued();
    drain();
    report("filtering");

    // both channels loaded with idle gaps, so a channel wakes up mid-message
    base = cmp_errors + seq_errors;
    gaps = 1'b1;
    repeat (8)
    begin
      queue_msg(1'b0, chance(75), 1 + $urandom % 4);
      queue_msg(1'b1, chance(75), 1 + $urandom % 4);
    end
    commit_queued();
    drain();
    gaps = 1'b0;
    report("both channels");

    base = cmp_errors + seq_errors;
    backpressure = 1'b1;
    repeat (24) queue_msg(chance(50), chance(70), 1 + $urandom % 4);
    commit_queued();
    drain();
    backpressure = 1'b0;
    report("backpressure");

    base = cmp_errors + seq_errors;
    queue_msg(1'b0, 1'b1, 1);
    commit_queued();
    drain();
    assert (lat_out - lat_in == sb_pkg::PIPE_LATENCY)
    else
    begin
      $display("Mismatch at %0t: idle latency %0d cycles, expected %0d",
               $time, lat_out - lat_in, sb_pkg::PIPE_LATENCY);
      seq_errors++;
    end
    report("idle latency");

    $display("6 tests, %0d flits compared, %0d errors", checks, cmp_errors + seq_errors);
    if (cmp_errors + seq_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
